//--- compile.f
common/boot_gpio_pkg.sv
common/boot_id_pkg.sv
ipid/ipid_collector.sv
design/sha_sequencer.sv
design/mem_port.sv
design/boot_sequencer.sv
design/boot_top.sv
bench/boot_checker.sv
bench/boot_tb.sv

//--- Makefile
# Verilator build and run for the boot controller testbench

VERILATOR ?= verilator
TOP       ?= boot_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/boot_tb.sv
// boot controller testbench with clock, reset, host GPIO model,
// SHA stand-in, secure memory model, two boot runs and timeout
`timescale 1ns/1ps

module boot_tb;
    import boot_gpio_pkg::*;
    import boot_id_pkg::*;

    localparam int clk_half    = 4;
    localparam int rot_lo      = 7;     // stand-in rotations
    localparam int rot_prev    = 1;
    localparam int mem_entries = 6;
    localparam int flip_bit    = 77;
    localparam int run_cycles  = 400;
    localparam int max_cycles  = 2 * run_cycles * 5;   // two runs, fivefold margin

    logic         clk;
    logic         rst;
    id_t          cam_puf;
    id_t          sha_puf;
    gpio_rdata_u  gpio_rdata;
    id_t          sha_digest;
    logic         sha_ready;
    logic         sha_digest_valid;
    id_t          mem_rdata;
    logic         mem_rdata_valid;
    logic         gpio_access;
    gpio_packet_t gpio_packet;
    sha_req_t     sha_req;
    mem_req_t     mem_req;
    logic         boot_done;
    logic         chip_authentic;

    id_t  ipid_ref [ipid_n];
    id_t  mem_array [mem_entries];
    logic corrupt;
    logic expect_auth;
    int   checks;
    int   errors;

    boot_top dut_i (
        .clk, .rst, .cam_puf, .sha_puf, .gpio_rdata,
        .sha_digest, .sha_ready, .sha_digest_valid, .mem_rdata, .mem_rdata_valid,
        .gpio_access, .gpio_packet, .sha_req, .mem_req, .boot_done, .chip_authentic
    );

    boot_checker chk_i (
        .clk, .rst, .cam_puf, .sha_puf, .ipid_ref, .expect_auth,
        .gpio_rdata, .gpio_access, .gpio_packet, .sha_req, .sha_ready, .sha_digest_valid,
        .mem_req, .boot_done, .chip_authentic, .checks, .errors
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    function automatic id_t rotl(input id_t v, input int n);
        return (v << n) | (v >> (id_width - n));
    endfunction

    function automatic id_t rand_id();
        id_t v;
        int  i;
        for (i = 0; i < id_width / 32; i++)
            v[i*32 +: 32] = $urandom;
        return v;
    endfunction

    // one halfword on the frame view, held for one cycle
    task automatic send_word(input logic [15:0] w);
        gpio_rdata                   = '0;
        gpio_rdata.frame.halfword    = w;
        gpio_rdata.frame.frame_valid = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic serve_host();
        int idx;
        int n;
        int w;
        bit cut;
        cut = 1'b1;
        n   = 0;
        while (!(gpio_packet.rw && gpio_packet.wr_data == cmd_bus_wakeup)) begin
            @(posedge clk);
            #1;
        end
        repeat (2 + $urandom % 8) @(posedge clk);
        #1;
        gpio_rdata                 = '0;
        gpio_rdata.status.wake_ack = 1'b1;
        while (n < ipid_n) begin
            while (!(gpio_packet.rw && gpio_packet.wr_data[12])) begin
                @(posedge clk);
                #1;
            end
            idx = int'(gpio_packet.wr_data[11:8]) % ipid_n;
            send_word(ipid_start_word);
            if (idx == 1 && cut) begin
                cut = 1'b0;                 // early stop on the first try
                for (w = 0; w < 5; w++)
                    send_word(ipid_ref[idx][w*16 +: 16]);
            end else begin
                for (w = 0; w < ipid_words; w++)
                    send_word(ipid_ref[idx][w*16 +: 16]);
                n++;
            end
            send_word(ipid_stop_word);
            gpio_rdata = '0;
        end
    endtask

    task automatic run_boot(input logic flip);
        corrupt     = flip;
        expect_auth = !flip;
        rst         = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        serve_host();
        while (!boot_done) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin : sha_model
        logic [2*id_width-1:0] blk;
        id_t                   acc;
        acc              = '0;
        sha_digest       = '0;
        sha_ready        = 1'b1;
        sha_digest_valid = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (sha_req.init || sha_req.next) begin
                blk = sha_req.block;
                if (sha_req.init)
                    acc = blk[2*id_width-1:id_width] ^ rotl(blk[id_width-1:0], rot_lo);
                else
                    acc = rotl(acc, rot_prev) ^ blk[2*id_width-1:id_width]
                          ^ rotl(blk[id_width-1:0], rot_lo);
                sha_ready        = 1'b0;
                sha_digest_valid = 1'b0;
                repeat (1 + $urandom % 6) @(posedge clk);
                #1;
                sha_digest       = acc;
                sha_digest_valid = 1'b1;
                sha_ready        = 1'b1;
            end
        end
    end

    initial begin : mem_model
        int i;
        for (i = 0; i < mem_entries; i++)
            mem_array[i] = {8{32'h5a5a_0000 | 32'(i)}};
        mem_rdata       = '0;
        mem_rdata_valid = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req.wr_en && int'(mem_req.addr) < mem_entries) begin
                mem_array[mem_req.addr] = mem_req.wr_data;
                if (corrupt)                // stored copy goes bad before read-back
                    mem_array[mem_req.addr][flip_bit] = ~mem_array[mem_req.addr][flip_bit];
            end
            if (mem_req.rd_en) begin
                repeat (1 + $urandom % 5) @(posedge clk);
                #1;
                mem_rdata = (int'(mem_req.addr) < mem_entries) ? mem_array[mem_req.addr] : '0;
                mem_rdata_valid = 1'b1;
                @(posedge clk);
                #1;
                mem_rdata_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, boot did not finish", max_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        int i;
        int w;
        logic [31:0] r;
        void'($urandom(32'h0f4f56bb));
        rst         = 1'b0;
        gpio_rdata  = '0;
        corrupt     = 1'b0;
        expect_auth = 1'b1;
        cam_puf     = rand_id();
        sha_puf     = rand_id();
        for (i = 0; i < ipid_n; i++) begin
            for (w = 0; w < ipid_words; w++) begin
                r = $urandom;
                if (r[15:0] == ipid_stop_word)
                    r[0] = ~r[0];           // keep data off the stop marker
                ipid_ref[i][w*16 +: 16] = r[15:0];
            end
        end
        run_boot(1'b0);
        run_boot(1'b1);
        $display("boot checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bench/boot_checker.sv
// boot controller checker with expected chip ID reference
// and protocol checks on GPIO, SHA and memory traffic
`timescale 1ns/1ps

module boot_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  boot_id_pkg::id_t            cam_puf,
    input  boot_id_pkg::id_t            sha_puf,
    input  boot_id_pkg::id_t            ipid_ref [boot_id_pkg::ipid_n],
    input  logic                        expect_auth,
    input  boot_gpio_pkg::gpio_rdata_u  gpio_rdata,
    input  logic                        gpio_access,
    input  boot_gpio_pkg::gpio_packet_t gpio_packet,
    input  boot_id_pkg::sha_req_t       sha_req,
    input  logic                        sha_ready,
    input  logic                        sha_digest_valid,
    input  boot_id_pkg::mem_req_t       mem_req,
    input  logic                        boot_done,
    input  logic                        chip_authentic,
    output int                          checks,
    output int                          errors
);
    import boot_gpio_pkg::*;
    import boot_id_pkg::*;

    localparam int rot_lo   = 7;
    localparam int rot_prev = 1;

    int                    n_checks = 0;
    int                    n_errors = 0;
    int                    cyc;
    int                    writes;
    int                    trig_q [$];
    bit                    strobe_q [$];
    gpio_packet_t          prev_pkt;
    logic                  wake_seen;
    logic                  ack_seen;
    logic                  prev_strobe;
    logic                  prev_done;
    logic                  pending;
    logic [2*id_width-1:0] held_block;

    assign checks = n_checks;
    assign errors = n_errors;

    function automatic id_t rotl(input id_t v, input int n);
        return (v << n) | (v >> (id_width - n));
    endfunction

    // expected chip ID from PUFs, frame data and the SHA stand-in rule
    function automatic id_t ref_chip_id();
        id_t h;
        id_t hi;
        id_t lo;
        int  p;
        h = '0;
        for (p = 0; p < ipid_n / 2; p++) begin
            hi = ipid_ref[2*p + 1];
            lo = ipid_ref[2*p];
            if (p == 0)
                h = hi ^ rotl(lo, rot_lo);
            else
                h = rotl(h, rot_prev) ^ hi ^ rotl(lo, rot_lo);
        end
        return rotl(cam_puf ^ sha_puf ^ h, rot_lo);     // zero upper half, init
    endfunction

    function automatic bit trig_order_ok();
        int exp_q [$];
        int i;
        for (i = 0; i < ipid_n; i++) begin
            exp_q.push_back(i);
            if (i == 1)
                exp_q.push_back(i);         // short frame asked again
        end
        if (exp_q.size() != trig_q.size())
            return 1'b0;
        for (i = 0; i < exp_q.size(); i++)
            if (exp_q[i] != trig_q[i])
                return 1'b0;
        return 1'b1;
    endfunction

    function automatic bit strobe_order_ok();
        int i;
        if (strobe_q.size() != ipid_n / 2 + 1)
            return 1'b0;
        for (i = 0; i < strobe_q.size(); i++)
            if (strobe_q[i] != (i == 0 || i == ipid_n / 2))
                return 1'b0;
        return 1'b1;
    endfunction

    task automatic check(input bit ok, input string msg);
        n_checks++;
        if (!ok) begin
            n_errors++;
            $display("mismatch at %0t: %s", $time, msg);
        end
    endtask

    always @(negedge clk) begin : monitor
        logic strobe;
        strobe = sha_req.init || sha_req.next;
        if (!rst) begin
            check(!gpio_access && !strobe && !mem_req.rd_en && !mem_req.wr_en
                  && !boot_done && !chip_authentic, "outputs not idle in reset");
            cyc         = 0;
            writes      = 0;
            prev_pkt    = '0;
            wake_seen   = 1'b0;
            ack_seen    = 1'b0;
            prev_strobe = 1'b0;
            prev_done   = 1'b0;
            pending     = 1'b0;
            trig_q.delete();
            strobe_q.delete();
        end else begin
            cyc++;
            if (gpio_access && gpio_packet.rw && gpio_packet != prev_pkt) begin
                if (!wake_seen) begin
                    check(gpio_packet.wr_data == cmd_bus_wakeup
                          && gpio_packet.data_type == gpio_odata,
                          "first write packet is not the wake-up command");
                    wake_seen = 1'b1;
                end else if (gpio_packet.wr_data[12]) begin
                    check(ack_seen, "trigger packet before wake ack");
                    trig_q.push_back(int'(gpio_packet.wr_data[11:8]));
                end
            end
            if (!wake_seen && cyc == 4)
                check(1'b0, "no wake-up packet within 3 cycles of reset release");
            if (wake_seen && gpio_rdata.status.wake_ack)
                ack_seen = 1'b1;
            prev_pkt = gpio_packet;

            if (strobe) begin
                check(!(sha_req.init && sha_req.next), "init and next strobes together");
                check(!prev_strobe, "SHA strobe longer than one cycle");
                if (!prev_strobe) begin
                    strobe_q.push_back(sha_req.init);
                    held_block = sha_req.block;
                    pending    = 1'b1;
                end
            end else if (pending) begin
                check(sha_req.block == held_block, "SHA block changed before ready");
                if (sha_ready && sha_digest_valid)
                    pending = 1'b0;
            end
            prev_strobe = strobe;

            if (mem_req.wr_en) begin
                writes++;
                check(mem_req.addr == chip_id_addr, "chip ID written to wrong address");
                check(mem_req.wr_data == ref_chip_id(),
                      $sformatf("written chip ID %h, expected %h",
                                mem_req.wr_data, ref_chip_id()));
            end
            if (mem_req.rd_en)
                check(mem_req.addr == chip_id_addr, "chip ID read from wrong address");

            if (boot_done && !prev_done) begin
                check(chip_authentic == expect_auth,
                      $sformatf("chip_authentic %0b, expected %0b", chip_authentic,
                                expect_auth));
                check(writes == 1, $sformatf("%0d memory writes, expected 1", writes));
                check(trig_order_ok(), "trigger indices not in order 0 1 1 2 3");
                check(strobe_order_ok(), "SHA strobe sequence is not init, next, init");
            end
            if (prev_done && !boot_done)
                check(1'b0, "boot_done dropped before reset");
            prev_done = boot_done;
        end
    end

endmodule

//--- design/boot_top.sv
// chip-identity boot controller top: sequencer with IP-ID collector,
// SHA block driver and secure memory port
`timescale 1ns/1ps

module boot_top (
    input  logic                        clk,
    input  logic                        rst,
    input  boot_id_pkg::id_t            cam_puf,
    input  boot_id_pkg::id_t            sha_puf,
    input  boot_gpio_pkg::gpio_rdata_u  gpio_rdata,
    input  boot_id_pkg::id_t            sha_digest,
    input  logic                        sha_ready,
    input  logic                        sha_digest_valid,
    input  boot_id_pkg::id_t            mem_rdata,
    input  logic                        mem_rdata_valid,
    output logic                        gpio_access,
    output boot_gpio_pkg::gpio_packet_t gpio_packet,
    output boot_id_pkg::sha_req_t       sha_req,
    output boot_id_pkg::mem_req_t       mem_req,
    output logic                        boot_done,
    output logic                        chip_authentic
);
    import boot_id_pkg::*;

    logic                      collect_start;
    logic                      collect_done;
    logic [$clog2(ipid_n)-1:0] pair_sel;
    logic [2*id_width-1:0]     ipid_pair;
    logic                      blk_start;
    logic                      blk_first;
    logic [2*id_width-1:0]     blk_data;
    logic                      blk_done;
    id_t                       digest;
    logic                      op_write;
    logic                      op_read;
    logic [mem_aw-1:0]         op_addr;
    id_t                       op_wdata;
    logic                      op_done;
    id_t                       rdata;

    boot_sequencer seq_i (
        .clk, .rst, .cam_puf, .sha_puf,
        .collect_done, .ipid_pair, .blk_done, .digest, .op_done, .rdata,
        .collect_start, .pair_sel, .blk_start, .blk_first, .blk_data,
        .op_write, .op_read, .op_addr, .op_wdata, .boot_done, .chip_authentic
    );

    ipid_collector col_i (
        .clk, .rst, .collect_start, .pair_sel, .gpio_rdata,
        .gpio_access, .gpio_packet, .collect_done, .ipid_pair
    );

    sha_sequencer sha_i (
        .clk, .rst, .blk_start, .blk_first, .blk_data,
        .sha_ready, .sha_digest_valid, .sha_digest,
        .sha_req, .blk_done, .digest
    );

    mem_port mem_i (
        .clk, .rst, .op_write, .op_read, .op_addr, .op_wdata,
        .mem_rdata, .mem_rdata_valid, .mem_req, .op_done, .rdata
    );

endmodule

//--- design/boot_sequencer.sv
// boot flow: MCSE ID, IP-ID collection and hash, chip-ID hash,
// store to secure memory, read-back and compare
`timescale 1ns/1ps

module boot_sequencer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  boot_id_pkg::id_t                       cam_puf,
    input  boot_id_pkg::id_t                       sha_puf,
    input  logic                                   collect_done,
    input  logic [2*boot_id_pkg::id_width-1:0]     ipid_pair,
    input  logic                                   blk_done,
    input  boot_id_pkg::id_t                       digest,
    input  logic                                   op_done,
    input  boot_id_pkg::id_t                       rdata,
    output logic                                   collect_start,
    output logic [$clog2(boot_id_pkg::ipid_n)-1:0] pair_sel,
    output logic                                   blk_start,
    output logic                                   blk_first,
    output logic [2*boot_id_pkg::id_width-1:0]     blk_data,
    output logic                                   op_write,
    output logic                                   op_read,
    output logic [boot_id_pkg::mem_aw-1:0]         op_addr,
    output boot_id_pkg::id_t                       op_wdata,
    output logic                                   boot_done,
    output logic                                   chip_authentic
);
    import boot_id_pkg::*;

    localparam int pw = $clog2(ipid_n);

    typedef enum logic [3:0] {
        B_MCSE, B_COLLECT, B_HASH, B_HWAIT, B_CHIP, B_CWAIT, B_WWAIT, B_RWAIT, B_DONE
    } boot_state_t;

    boot_state_t state;
    id_t         mcse_id;
    id_t         chip_id;

    assign op_addr  = chip_id_addr;
    assign op_wdata = chip_id;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= B_MCSE;
            collect_start  <= 1'b0;
            pair_sel       <= '0;
            blk_start      <= 1'b0;
            blk_first      <= 1'b0;
            op_write       <= 1'b0;
            op_read        <= 1'b0;
            boot_done      <= 1'b0;
            chip_authentic <= 1'b0;
        end else begin
            collect_start <= 1'b0;
            blk_start     <= 1'b0;
            op_write      <= 1'b0;
            op_read       <= 1'b0;
            case (state)
                B_MCSE: begin
                    collect_start <= 1'b1;
                    state         <= B_COLLECT;
                end
                B_COLLECT: begin
                    if (collect_done) begin
                        pair_sel <= '0;
                        state    <= B_HASH;
                    end
                end
                B_HASH: begin
                    blk_start <= 1'b1;
                    blk_first <= pair_sel == '0;    // init only on the first pair
                    state     <= B_HWAIT;
                end
                B_HWAIT: begin
                    if (blk_done) begin
                        if (pair_sel == pw'(ipid_n/2 - 1)) begin
                            state <= B_CHIP;
                        end else begin
                            pair_sel <= pair_sel + 1'b1;
                            state    <= B_HASH;
                        end
                    end
                end
                B_CHIP: begin
                    blk_start <= 1'b1;
                    blk_first <= 1'b1;              // new message
                    state     <= B_CWAIT;
                end
                B_CWAIT: begin
                    if (blk_done) begin
                        op_write <= 1'b1;
                        state    <= B_WWAIT;
                    end
                end
                B_WWAIT: begin
                    if (op_done) begin
                        op_read <= 1'b1;
                        state   <= B_RWAIT;
                    end
                end
                B_RWAIT: begin
                    if (op_done) begin
                        chip_authentic <= rdata == chip_id;
                        boot_done      <= 1'b1;
                        state          <= B_DONE;
                    end
                end
                B_DONE: state <= B_DONE;   // held until reset
                default: state <= B_MCSE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == B_MCSE)
            mcse_id <= cam_puf ^ sha_puf;
        if (state == B_HASH)
            blk_data <= ipid_pair;
        if (state == B_CHIP)
            blk_data <= {{id_width{1'b0}}, mcse_id ^ digest};
        if (state == B_CWAIT && blk_done)
            chip_id <= digest;
    end

endmodule

//--- design/mem_port.sv
// secure memory port: one-cycle write pulse, read request held
// until data returns
`timescale 1ns/1ps

module mem_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           op_write,
    input  logic                           op_read,
    input  logic [boot_id_pkg::mem_aw-1:0] op_addr,
    input  boot_id_pkg::id_t               op_wdata,
    input  boot_id_pkg::id_t               mem_rdata,
    input  logic                           mem_rdata_valid,
    output boot_id_pkg::mem_req_t          mem_req,
    output logic                           op_done,
    output boot_id_pkg::id_t               rdata
);

    typedef enum logic [1:0] {M_IDLE, M_WREL, M_RWAIT} mem_state_t;

    mem_state_t state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= M_IDLE;
            mem_req <= '0;
            op_done <= 1'b0;
        end else begin
            op_done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (op_write) begin
                        mem_req.wr_en   <= 1'b1;
                        mem_req.addr    <= op_addr;
                        mem_req.wr_data <= op_wdata;
                        state           <= M_WREL;
                    end else if (op_read) begin
                        mem_req.rd_en <= 1'b1;
                        mem_req.addr  <= op_addr;
                        state         <= M_RWAIT;
                    end
                end
                M_WREL: begin
                    mem_req.wr_en <= 1'b0;
                    op_done       <= 1'b1;
                    state         <= M_IDLE;
                end
                M_RWAIT: begin
                    if (mem_rdata_valid) begin
                        mem_req.rd_en <= 1'b0;
                        op_done       <= 1'b1;
                        state         <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_RWAIT && mem_rdata_valid)
            rdata <= mem_rdata;
    end

endmodule

//--- design/sha_sequencer.sv
// SHA block driver: one init or next strobe per block, then waits
// for the engine and captures the digest
`timescale 1ns/1ps

module sha_sequencer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               blk_start,
    input  logic                               blk_first,
    input  logic [2*boot_id_pkg::id_width-1:0] blk_data,
    input  logic                               sha_ready,
    input  logic                               sha_digest_valid,
    input  boot_id_pkg::id_t                   sha_digest,
    output boot_id_pkg::sha_req_t              sha_req,
    output logic                               blk_done,
    output boot_id_pkg::id_t                   digest
);

    typedef enum logic [1:0] {SH_IDLE, SH_REL, SH_WAIT} sha_state_t;

    sha_state_t state;
    logic       accept;

    // ready is only trusted two cycles past the strobe
    assign accept = state == SH_WAIT && sha_ready && sha_digest_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= SH_IDLE;
            sha_req  <= '0;
            blk_done <= 1'b0;
        end else begin
            blk_done <= 1'b0;
            case (state)
                SH_IDLE: begin
                    if (blk_start) begin
                        sha_req.block <= blk_data;  // held until accept
                        sha_req.init  <= blk_first;
                        sha_req.next  <= !blk_first;
                        state         <= SH_REL;
                    end
                end
                SH_REL: begin
                    sha_req.init <= 1'b0;
                    sha_req.next <= 1'b0;
                    state        <= SH_WAIT;
                end
                SH_WAIT: begin
                    if (accept) begin
                        blk_done <= 1'b1;
                        state    <= SH_IDLE;
                    end
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            digest <= sha_digest;
    end

endmodule

//--- ipid/ipid_collector.sv
// IP-ID collection over the GPIO channel: host wake-up, per-ID trigger,
// framed reception and storage, pair read port for hashing
`timescale 1ns/1ps

module ipid_collector (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   collect_start,
    input  logic [$clog2(boot_id_pkg::ipid_n)-1:0] pair_sel,
    input  boot_gpio_pkg::gpio_rdata_u             gpio_rdata,
    output logic                                   gpio_access,
    output boot_gpio_pkg::gpio_packet_t            gpio_packet,
    output logic                                   collect_done,
    output logic [2*boot_id_pkg::id_width-1:0]     ipid_pair
);
    import boot_gpio_pkg::*;
    import boot_id_pkg::*;

    localparam int iw = $clog2(ipid_n);
    localparam int ww = $clog2(ipid_words);

    localparam gpio_packet_t rd_pkt = '{wr_data: '0, data_type: gpio_idata, rw: 1'b0};

    typedef enum logic [2:0] {
        C_IDLE, C_WAKE, C_ACK, C_TRIG, C_START, C_DATA, C_STOP
    } col_state_t;

    col_state_t        state;
    logic [iw-1:0]     id_idx;
    logic [ww-1:0]     word_idx;
    logic [iw-1:0]     lo_sel;
    logic [gpio_n-1:0] trig_word;
    logic              frame_ok;
    logic              is_stop;
    id_t               ids [ipid_n];

    assign frame_ok = gpio_rdata.frame.frame_valid;
    assign is_stop  = gpio_rdata.frame.halfword == ipid_stop_word;

    // trigger flag plus ID index
    always_comb begin
        trig_word        = '0;
        trig_word[12]    = 1'b1;
        trig_word[11:8]  = 4'(id_idx);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= C_IDLE;
            id_idx       <= '0;
            word_idx     <= '0;
            gpio_access  <= 1'b0;
            gpio_packet  <= '0;
            collect_done <= 1'b0;
        end else begin
            collect_done <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (collect_start) begin
                        gpio_access <= 1'b1;
                        gpio_packet <= '{wr_data: cmd_bus_wakeup, data_type: gpio_odata,
                                         rw: 1'b1};
                        id_idx      <= '0;
                        state       <= C_WAKE;
                    end
                end
                C_WAKE: begin
                    gpio_packet <= rd_pkt;
                    state       <= C_ACK;
                end
                C_ACK: begin
                    if (gpio_rdata.status.wake_ack)
                        state <= C_TRIG;
                end
                C_TRIG: begin
                    gpio_packet <= '{wr_data: trig_word, data_type: gpio_odata, rw: 1'b1};
                    word_idx    <= '0;
                    state       <= C_START;
                end
                C_START: begin
                    gpio_packet <= rd_pkt;
                    if (frame_ok && gpio_rdata.frame.halfword == ipid_start_word)
                        state <= C_DATA;
                end
                C_DATA: begin
                    if (frame_ok) begin
                        if (is_stop) begin
                            state <= C_TRIG;    // short frame, ask again
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            if (word_idx == ww'(ipid_words - 1))
                                state <= C_STOP;
                        end
                    end
                end
                C_STOP: begin
                    if (frame_ok) begin
                        state <= C_TRIG;        // missing stop also retriggers
                        if (is_stop) begin
                            id_idx <= id_idx + 1'b1;
                            if (id_idx == iw'(ipid_n - 1)) begin
                                state        <= C_IDLE;
                                gpio_access  <= 1'b0;
                                collect_done <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // first halfword lands in the low bits; a retry overwrites every word
    always_ff @(posedge clk) begin
        if (state == C_DATA && frame_ok && !is_stop)
            ids[id_idx][word_idx*16 +: 16] <= gpio_rdata.frame.halfword;
    end

    assign lo_sel    = iw'({pair_sel, 1'b0});
    assign ipid_pair = {ids[lo_sel + 1'b1], ids[lo_sel]};

endmodule

//--- common/boot_id_pkg.sv
// identity widths, IP-ID count, secure memory layout
// and the SHA and memory request structs
package boot_id_pkg;

    localparam int id_width   = 256;
    localparam int ipid_n     = 4;      // hashed two at a time, keep even
    localparam int ipid_words = 16;     // 16-bit words per IP ID

    localparam int mem_aw = 3;
    localparam int mem_dw = 256;

    localparam logic [mem_aw-1:0] chip_id_addr = '0;

    typedef logic [id_width-1:0] id_t;

    typedef struct packed {
        logic [2*id_width-1:0] block;
        logic                  init;    // first block of a message
        logic                  next;    // continuation block
    } sha_req_t;

    typedef struct packed {
        logic              rd_en;
        logic              wr_en;
        logic [mem_aw-1:0] addr;
        logic [mem_dw-1:0] wr_data;
    } mem_req_t;

endpackage

//--- common/boot_gpio_pkg.sv
// GPIO register channel definitions: packet layout, read-word views,
// register codes, host commands and IP-ID frame markers
package boot_gpio_pkg;

    localparam int gpio_n = 32;

    // register codes seen by the host
    localparam logic [5:0] gpio_odata = 6'h0;
    localparam logic [5:0] gpio_idata = 6'h5;

    localparam logic [gpio_n-1:0] cmd_bus_wakeup = 32'h0000_0040;

    localparam logic [15:0] ipid_start_word = 16'h7A7A;
    localparam logic [15:0] ipid_stop_word  = 16'hB9B9;

    // host packet, same field order as the full register packet
    typedef struct packed {
        logic [gpio_n-1:0] wr_data;
        logic [5:0]        data_type;
        logic              rw;          // 1 write, 0 read
    } gpio_packet_t;

    localparam int gpio_pw = $bits(gpio_packet_t);

    typedef struct packed {
        logic [23:0] rsvd_hi;
        logic        wake_ack;
        logic [6:0]  rsvd_lo;
    } gpio_status_t;

    typedef struct packed {
        logic [15:0] halfword;
        logic [1:0]  rsvd_hi;
        logic        frame_valid;       // one halfword per cycle while high
        logic [12:0] rsvd_lo;
    } gpio_frame_t;

    // read word, decoded as status or as ID frame depending on phase
    typedef union packed {
        gpio_status_t status;
        gpio_frame_t  frame;
    } gpio_rdata_u;

endpackage
